//--- Makefile
TOP := tb_axi_crossbar

SRCS := $(shell cat axi_crossbar.f)

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): axi_crossbar.f $(SRCS)
	verilator --binary --timing --assert -f axi_crossbar.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing -f axi_crossbar.f --top-module axi_crossbar

clean:
	rm -rf obj_dir

//--- axi_crossbar.f
rtl/axi_xbar_pkg.sv
rtl/axi_read_arbiter.sv
rtl/axi_slave_router.sv
rtl/axi_write_path.sv
rtl/axi_crossbar.sv
tests/tb_slave_model.sv
tests/tb_axi_crossbar.sv

//--- rtl/axi_crossbar.sv
`timescale 1ns/1ps
`default_nettype none

module axi_crossbar #(
    parameter int MMIO_SEL_BIT = 29
) (
    input  wire                             clk,
    input  wire                             rst_i,
    // instruction fetch, read only
    input  wire                             if_ar_valid_i,
    output logic                            if_ar_ready_o,
    input  wire axi_xbar_pkg::addr_chan_t   if_ar_i,
    output logic                            if_r_valid_o,
    input  wire                             if_r_ready_i,
    output axi_xbar_pkg::r_chan_t           if_r_o,
    // load-store
    input  wire                             ls_ar_valid_i,
    output logic                            ls_ar_ready_o,
    input  wire axi_xbar_pkg::addr_chan_t   ls_ar_i,
    output logic                            ls_r_valid_o,
    input  wire                             ls_r_ready_i,
    output axi_xbar_pkg::r_chan_t           ls_r_o,
    input  wire                             ls_aw_valid_i,
    output logic                            ls_aw_ready_o,
    input  wire axi_xbar_pkg::addr_chan_t   ls_aw_i,
    input  wire                             ls_w_valid_i,
    output logic                            ls_w_ready_o,
    input  wire axi_xbar_pkg::w_chan_t      ls_w_i,
    output logic                            ls_b_valid_o,
    input  wire                             ls_b_ready_i,
    output axi_xbar_pkg::b_chan_t           ls_b_o,
    // main memory
    output logic                            mem_ar_valid_o,
    input  wire                             mem_ar_ready_i,
    output axi_xbar_pkg::addr_chan_t        mem_ar_o,
    input  wire                             mem_r_valid_i,
    output logic                            mem_r_ready_o,
    input  wire axi_xbar_pkg::r_chan_t      mem_r_i,
    output logic                            mem_aw_valid_o,
    input  wire                             mem_aw_ready_i,
    output axi_xbar_pkg::addr_chan_t        mem_aw_o,
    output logic                            mem_w_valid_o,
    input  wire                             mem_w_ready_i,
    output axi_xbar_pkg::w_chan_t           mem_w_o,
    input  wire                             mem_b_valid_i,
    output logic                            mem_b_ready_o,
    input  wire axi_xbar_pkg::b_chan_t      mem_b_i,
    // mmio
    output logic                            mmio_ar_valid_o,
    input  wire                             mmio_ar_ready_i,
    output axi_xbar_pkg::addr_chan_t        mmio_ar_o,
    input  wire                             mmio_r_valid_i,
    output logic                            mmio_r_ready_o,
    input  wire axi_xbar_pkg::r_chan_t      mmio_r_i,
    output logic                            mmio_aw_valid_o,
    input  wire                             mmio_aw_ready_i,
    output axi_xbar_pkg::addr_chan_t        mmio_aw_o,
    output logic                            mmio_w_valid_o,
    input  wire                             mmio_w_ready_i,
    output axi_xbar_pkg::w_chan_t           mmio_w_o,
    input  wire                             mmio_b_valid_i,
    output logic                            mmio_b_ready_o,
    input  wire axi_xbar_pkg::b_chan_t      mmio_b_i
);
    import axi_xbar_pkg::*;

    logic       ar_valid;   // merged read channel
    logic       ar_ready;
    addr_chan_t ar;
    logic       r_valid;
    logic       r_ready;
    r_chan_t    r;

    axi_read_arbiter i_read_arbiter (
        .clk           (clk),
        .rst_i         (rst_i),
        .if_ar_valid_i (if_ar_valid_i),
        .if_ar_ready_o (if_ar_ready_o),
        .if_ar_i       (if_ar_i),
        .if_r_valid_o  (if_r_valid_o),
        .if_r_ready_i  (if_r_ready_i),
        .if_r_o        (if_r_o),
        .ls_ar_valid_i (ls_ar_valid_i),
        .ls_ar_ready_o (ls_ar_ready_o),
        .ls_ar_i       (ls_ar_i),
        .ls_r_valid_o  (ls_r_valid_o),
        .ls_r_ready_i  (ls_r_ready_i),
        .ls_r_o        (ls_r_o),
        .ar_valid_o    (ar_valid),
        .ar_ready_i    (ar_ready),
        .ar_o          (ar),
        .r_valid_i     (r_valid),
        .r_ready_o     (r_ready),
        .r_i           (r)
    );

    axi_slave_router #(
        .MMIO_SEL_BIT (MMIO_SEL_BIT),
        .rsp_t        (r_chan_t)
    ) i_read_router (
        .clk              (clk),
        .rst_i            (rst_i),
        .req_valid_i      (ar_valid),
        .req_ready_o      (ar_ready),
        .req_i            (ar),
        .rsp_valid_o      (r_valid),
        .rsp_ready_i      (r_ready),
        .rsp_o            (r),
        .mem_req_valid_o  (mem_ar_valid_o),
        .mem_req_ready_i  (mem_ar_ready_i),
        .mem_req_o        (mem_ar_o),
        .mem_rsp_valid_i  (mem_r_valid_i),
        .mem_rsp_ready_o  (mem_r_ready_o),
        .mem_rsp_i        (mem_r_i),
        .mmio_req_valid_o (mmio_ar_valid_o),
        .mmio_req_ready_i (mmio_ar_ready_i),
        .mmio_req_o       (mmio_ar_o),
        .mmio_rsp_valid_i (mmio_r_valid_i),
        .mmio_rsp_ready_o (mmio_r_ready_o),
        .mmio_rsp_i       (mmio_r_i),
        .route_o          (),
        .locked_o         ()
    );

    axi_write_path #(
        .MMIO_SEL_BIT (MMIO_SEL_BIT)
    ) i_write_path (
        .clk             (clk),
        .rst_i           (rst_i),
        .aw_valid_i      (ls_aw_valid_i),
        .aw_ready_o      (ls_aw_ready_o),
        .aw_i            (ls_aw_i),
        .w_valid_i       (ls_w_valid_i),
        .w_ready_o       (ls_w_ready_o),
        .w_i             (ls_w_i),
        .b_valid_o       (ls_b_valid_o),
        .b_ready_i       (ls_b_ready_i),
        .b_o             (ls_b_o),
        .mem_aw_valid_o  (mem_aw_valid_o),
        .mem_aw_ready_i  (mem_aw_ready_i),
        .mem_aw_o        (mem_aw_o),
        .mem_w_valid_o   (mem_w_valid_o),
        .mem_w_ready_i   (mem_w_ready_i),
        .mem_w_o         (mem_w_o),
        .mem_b_valid_i   (mem_b_valid_i),
        .mem_b_ready_o   (mem_b_ready_o),
        .mem_b_i         (mem_b_i),
        .mmio_aw_valid_o (mmio_aw_valid_o),
        .mmio_aw_ready_i (mmio_aw_ready_i),
        .mmio_aw_o       (mmio_aw_o),
        .mmio_w_valid_o  (mmio_w_valid_o),
        .mmio_w_ready_i  (mmio_w_ready_i),
        .mmio_w_o        (mmio_w_o),
        .mmio_b_valid_i  (mmio_b_valid_i),
        .mmio_b_ready_o  (mmio_b_ready_o),
        .mmio_b_i        (mmio_b_i)
    );

endmodule

`default_nettype wire

//--- rtl/axi_read_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_arbiter (
    input  wire                             clk,
    input  wire                             rst_i,
    input  wire                             if_ar_valid_i,
    output logic                            if_ar_ready_o,
    input  wire axi_xbar_pkg::addr_chan_t   if_ar_i,
    output logic                            if_r_valid_o,
    input  wire                             if_r_ready_i,
    output axi_xbar_pkg::r_chan_t           if_r_o,
    input  wire                             ls_ar_valid_i,
    output logic                            ls_ar_ready_o,
    input  wire axi_xbar_pkg::addr_chan_t   ls_ar_i,
    output logic                            ls_r_valid_o,
    input  wire                             ls_r_ready_i,
    output axi_xbar_pkg::r_chan_t           ls_r_o,
    output logic                            ar_valid_o,
    input  wire                             ar_ready_i,
    output axi_xbar_pkg::addr_chan_t        ar_o,
    input  wire                             r_valid_i,
    output logic                            r_ready_o,
    input  wire axi_xbar_pkg::r_chan_t      r_i
);
    import axi_xbar_pkg::*;

    logic [1:0] grant_q;    // one-hot {ls, if}, zero when idle
    logic       last_ls_q;  // ls won the last grant
    logic       ar_pend_q;  // granted AR not yet taken downstream
    addr_chan_t ar_q;
    logic       take;
    logic       pick_ls;
    logic       r_hs;

    assign take    = (grant_q == 2'b00) && (if_ar_valid_i || ls_ar_valid_i);
    assign pick_ls = ls_ar_valid_i && (!if_ar_valid_i || !last_ls_q); // tie goes to the other

    assign if_ar_ready_o = take && !pick_ls;
    assign ls_ar_ready_o = take && pick_ls;

    assign ar_valid_o = ar_pend_q;
    assign ar_o       = ar_q;

    assign r_ready_o = (grant_q[0] && if_r_ready_i) || (grant_q[1] && ls_r_ready_i);
    assign r_hs      = r_valid_i && r_ready_o;

    assign if_r_valid_o = r_valid_i && grant_q[0];
    assign ls_r_valid_o = r_valid_i && grant_q[1];
    assign if_r_o       = r_i;
    assign ls_r_o       = r_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            grant_q   <= 2'b00;
            last_ls_q <= 1'b0;
            ar_pend_q <= 1'b0;
        end else if (take) begin
            grant_q   <= pick_ls ? 2'b10 : 2'b01;
            last_ls_q <= pick_ls;
            ar_pend_q <= 1'b1;
        end else begin
            if (ar_valid_o && ar_ready_i)
                ar_pend_q <= 1'b0;
            if (r_hs)
                grant_q <= 2'b00; // free again next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            ar_q <= pick_ls ? ls_ar_i : if_ar_i;
    end

    a_grant_hold: assert property (@(posedge clk) disable iff (rst_i)
        (grant_q != 2'b00 && !r_hs) |=> $stable(grant_q));

endmodule

`default_nettype wire

//--- rtl/axi_slave_router.sv
`timescale 1ns/1ps
`default_nettype none

module axi_slave_router #(
    parameter int  MMIO_SEL_BIT = 29,
    parameter type rsp_t        = axi_xbar_pkg::r_chan_t
) (
    input  wire                             clk,
    input  wire                             rst_i,

    // upstream
    input  wire                             req_valid_i,
    output logic                            req_ready_o,
    input  wire axi_xbar_pkg::addr_chan_t   req_i,
    output logic                            rsp_valid_o,
    input  wire                             rsp_ready_i,
    output rsp_t                            rsp_o,

    // main memory
    output logic                            mem_req_valid_o,
    input  wire                             mem_req_ready_i,
    output axi_xbar_pkg::addr_chan_t        mem_req_o,
    input  wire                             mem_rsp_valid_i,
    output logic                            mem_rsp_ready_o,
    input  wire rsp_t                       mem_rsp_i,

    // peripheral space
    output logic                            mmio_req_valid_o,
    input  wire                             mmio_req_ready_i,
    output axi_xbar_pkg::addr_chan_t        mmio_req_o,
    input  wire                             mmio_rsp_valid_i,
    output logic                            mmio_rsp_ready_o,
    input  wire rsp_t                       mmio_rsp_i,

    output logic                            route_o,
    output logic                            locked_o
);

    logic locked_q;
    logic route_q;  // 1 = mmio
    logic sel;
    logic req_hs;
    logic rsp_hs;

    assign sel = req_i.addr[MMIO_SEL_BIT];

    // address path, same cycle
    assign mem_req_valid_o  = req_valid_i && !locked_q && !sel;
    assign mmio_req_valid_o = req_valid_i && !locked_q && sel;
    assign mem_req_o        = req_i;
    assign mmio_req_o       = req_i;

    assign req_ready_o = !locked_q && (sel ? mmio_req_ready_i : mem_req_ready_i);
    assign req_hs      = req_valid_i && req_ready_o;

    // response only from the locked slave
    assign rsp_valid_o = locked_q && (route_q ? mmio_rsp_valid_i : mem_rsp_valid_i);
    assign rsp_o       = route_q ? mmio_rsp_i : mem_rsp_i;

    assign mem_rsp_ready_o  = locked_q && !route_q && rsp_ready_i;
    assign mmio_rsp_ready_o = locked_q && route_q && rsp_ready_i;
    assign rsp_hs           = rsp_valid_o && rsp_ready_i;

    assign route_o  = route_q;
    assign locked_o = locked_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            locked_q <= 1'b0;
            route_q  <= 1'b0;
        end else if (req_hs) begin
            locked_q <= 1'b1;
            route_q  <= sel;
        end else if (rsp_hs) begin
            locked_q <= 1'b0;
        end
    end

    // one transaction in flight
    a_no_second_req: assert property (@(posedge clk) disable iff (rst_i)
        req_hs |=> !req_ready_o);

    a_no_rsp_unlocked: assert property (@(posedge clk) disable iff (rst_i)
        rsp_hs |=> !rsp_valid_o);

endmodule

`default_nettype wire

//--- rtl/axi_write_path.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_path #(
    parameter int MMIO_SEL_BIT = 29
) (
    input  wire                             clk,
    input  wire                             rst_i,
    input  wire                             aw_valid_i,
    output logic                            aw_ready_o,
    input  wire axi_xbar_pkg::addr_chan_t   aw_i,
    input  wire                             w_valid_i,
    output logic                            w_ready_o,
    input  wire axi_xbar_pkg::w_chan_t      w_i,
    output logic                            b_valid_o,
    input  wire                             b_ready_i,
    output axi_xbar_pkg::b_chan_t           b_o,
    output logic                            mem_aw_valid_o,
    input  wire                             mem_aw_ready_i,
    output axi_xbar_pkg::addr_chan_t        mem_aw_o,
    output logic                            mem_w_valid_o,
    input  wire                             mem_w_ready_i,
    output axi_xbar_pkg::w_chan_t           mem_w_o,
    input  wire                             mem_b_valid_i,
    output logic                            mem_b_ready_o,
    input  wire axi_xbar_pkg::b_chan_t      mem_b_i,
    output logic                            mmio_aw_valid_o,
    input  wire                             mmio_aw_ready_i,
    output axi_xbar_pkg::addr_chan_t        mmio_aw_o,
    output logic                            mmio_w_valid_o,
    input  wire                             mmio_w_ready_i,
    output axi_xbar_pkg::w_chan_t           mmio_w_o,
    input  wire                             mmio_b_valid_i,
    output logic                            mmio_b_ready_o,
    input  wire axi_xbar_pkg::b_chan_t      mmio_b_i
);

    logic route;
    logic locked;
    logic w_pend_q; // address taken, data not yet
    logic aw_hs;
    logic w_hs;

    axi_slave_router #(
        .MMIO_SEL_BIT (MMIO_SEL_BIT),
        .rsp_t        (axi_xbar_pkg::b_chan_t)
    ) i_aw_router (
        .clk              (clk),
        .rst_i            (rst_i),
        .req_valid_i      (aw_valid_i),
        .req_ready_o      (aw_ready_o),
        .req_i            (aw_i),
        .rsp_valid_o      (b_valid_o),
        .rsp_ready_i      (b_ready_i),
        .rsp_o            (b_o),
        .mem_req_valid_o  (mem_aw_valid_o),
        .mem_req_ready_i  (mem_aw_ready_i),
        .mem_req_o        (mem_aw_o),
        .mem_rsp_valid_i  (mem_b_valid_i),
        .mem_rsp_ready_o  (mem_b_ready_o),
        .mem_rsp_i        (mem_b_i),
        .mmio_req_valid_o (mmio_aw_valid_o),
        .mmio_req_ready_i (mmio_aw_ready_i),
        .mmio_req_o       (mmio_aw_o),
        .mmio_rsp_valid_i (mmio_b_valid_i),
        .mmio_rsp_ready_o (mmio_b_ready_o),
        .mmio_rsp_i       (mmio_b_i),
        .route_o          (route),
        .locked_o         (locked)
    );

    assign aw_hs = aw_valid_i && aw_ready_o;
    assign w_hs  = w_valid_i && w_ready_o;

    assign mem_w_valid_o  = w_pend_q && !route && w_valid_i;
    assign mmio_w_valid_o = w_pend_q && route && w_valid_i;
    assign mem_w_o        = w_i;
    assign mmio_w_o       = w_i;
    assign w_ready_o      = w_pend_q && (route ? mmio_w_ready_i : mem_w_ready_i);

    always_ff @(posedge clk) begin
        if (rst_i)
            w_pend_q <= 1'b0;
        else if (aw_hs)
            w_pend_q <= 1'b1;
        else if (w_hs)
            w_pend_q <= 1'b0;
    end

    a_w_needs_aw: assert property (@(posedge clk) disable iff (rst_i)
        (mem_w_valid_o || mmio_w_valid_o) |-> locked);

endmodule

`default_nettype wire

//--- rtl/axi_xbar_pkg.sv
`default_nettype none

package axi_xbar_pkg;

    parameter int AXI_ADDR_W = 32;
    parameter int AXI_DATA_W = 64;
    parameter int AXI_STRB_W = AXI_DATA_W / 8;

    parameter logic [1:0] RESP_OKAY = 2'b00;

    // AR and AW share one layout
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] addr;
        logic [2:0]            prot;
    } addr_chan_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
    } w_chan_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
    } r_chan_t;

    typedef struct packed {
        logic [1:0] resp;
    } b_chan_t;

endpackage

`default_nettype wire

//--- tests/tb_axi_crossbar.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_crossbar;
    import axi_xbar_pkg::*;

    localparam int MMIO_SEL_BIT = 29;
    localparam int SEED         = 69308;
    localparam int N_IF_RD      = 70;
    localparam int N_LS_RD      = 70;
    localparam int N_LS_WR      = 60;
    localparam int MAX_CYCLES   = (N_IF_RD + N_LS_RD + N_LS_WR) * 40;

    logic       clk, rst_i;
    logic       if_ar_valid_i, if_ar_ready_o, if_r_valid_o, if_r_ready_i;
    addr_chan_t if_ar_i;
    r_chan_t    if_r_o;
    logic       ls_ar_valid_i, ls_ar_ready_o, ls_r_valid_o, ls_r_ready_i;
    addr_chan_t ls_ar_i;
    r_chan_t    ls_r_o;
    logic       ls_aw_valid_i, ls_aw_ready_o, ls_w_valid_i, ls_w_ready_o;
    logic       ls_b_valid_o, ls_b_ready_i;
    addr_chan_t ls_aw_i;
    w_chan_t    ls_w_i;
    b_chan_t    ls_b_o;
    logic       mem_ar_valid_o, mem_ar_ready_i, mem_r_valid_i, mem_r_ready_o;
    logic       mem_aw_valid_o, mem_aw_ready_i, mem_w_valid_o, mem_w_ready_i;
    logic       mem_b_valid_i, mem_b_ready_o;
    addr_chan_t mem_ar_o, mem_aw_o;
    r_chan_t    mem_r_i;
    w_chan_t    mem_w_o;
    b_chan_t    mem_b_i;
    logic       mmio_ar_valid_o, mmio_ar_ready_i, mmio_r_valid_i, mmio_r_ready_o;
    logic       mmio_aw_valid_o, mmio_aw_ready_i, mmio_w_valid_o, mmio_w_ready_i;
    logic       mmio_b_valid_i, mmio_b_ready_o;
    addr_chan_t mmio_ar_o, mmio_aw_o;
    r_chan_t    mmio_r_i;
    w_chan_t    mmio_w_o;
    b_chan_t    mmio_b_i;

    integer     seed = SEED;
    logic       go;
    int         cycles = 0;
    int         if_count = 0;
    int         ls_count = 0;
    int         wr_count = 0;
    int         mem_logged = 0;
    int         mmio_logged = 0;
    int         if_passed = 0;  // ls reads finished while if waits
    int         ls_passed = 0;
    addr_chan_t if_exp[$];
    addr_chan_t ls_exp[$];
    addr_chan_t aw_exp[$];
    w_chan_t    w_exp[$];
    addr_chan_t ar_granted;     // last read address taken from a master
    b_chan_t    okay_b;

    axi_crossbar #(.MMIO_SEL_BIT(MMIO_SEL_BIT)) i_dut (.*);

    tb_slave_model #(.SEED(SEED + 1), .INVERT(1'b0)) i_mem (
        .clk        (clk),
        .rst_i      (rst_i),
        .ar_valid_i (mem_ar_valid_o),
        .ar_ready_o (mem_ar_ready_i),
        .ar_i       (mem_ar_o),
        .r_valid_o  (mem_r_valid_i),
        .r_ready_i  (mem_r_ready_o),
        .r_o        (mem_r_i),
        .aw_valid_i (mem_aw_valid_o),
        .aw_ready_o (mem_aw_ready_i),
        .aw_i       (mem_aw_o),
        .w_valid_i  (mem_w_valid_o),
        .w_ready_o  (mem_w_ready_i),
        .w_i        (mem_w_o),
        .b_valid_o  (mem_b_valid_i),
        .b_ready_i  (mem_b_ready_o),
        .b_o        (mem_b_i)
    );

    tb_slave_model #(.SEED(SEED + 2), .INVERT(1'b1)) i_mmio (
        .clk        (clk),
        .rst_i      (rst_i),
        .ar_valid_i (mmio_ar_valid_o),
        .ar_ready_o (mmio_ar_ready_i),
        .ar_i       (mmio_ar_o),
        .r_valid_o  (mmio_r_valid_i),
        .r_ready_i  (mmio_r_ready_o),
        .r_o        (mmio_r_i),
        .aw_valid_i (mmio_aw_valid_o),
        .aw_ready_o (mmio_aw_ready_i),
        .aw_i       (mmio_aw_o),
        .w_valid_i  (mmio_w_valid_o),
        .w_ready_o  (mmio_w_ready_i),
        .w_i        (mmio_w_o),
        .b_valid_o  (mmio_b_valid_i),
        .b_ready_i  (mmio_b_ready_o),
        .b_o        (mmio_b_i)
    );

    task automatic stop_with(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_r(input r_chan_t got, input r_chan_t exp, input string what);
        if (got !== exp)
            stop_with($sformatf("Error at %0t ns: %s got %h, expected %h", $time, what, got, exp));
    endtask

    task automatic compare_b(input b_chan_t got, input b_chan_t exp, input string what);
        if (got !== exp)
            stop_with($sformatf("Error at %0t ns: %s got %h, expected %h", $time, what, got, exp));
    endtask

    task automatic compare_addr(input addr_chan_t got, input addr_chan_t exp, input string what);
        if (got !== exp)
            stop_with($sformatf("Error at %0t ns: %s got %h, expected %h", $time, what, got, exp));
    endtask

    task automatic compare_w(input w_chan_t got, input w_chan_t exp, input string what);
        if (got !== exp)
            stop_with($sformatf("Error at %0t ns: %s got %h, expected %h", $time, what, got, exp));
    endtask

    function automatic logic chance(input int pct);
        logic [31:0] r;
        r = $random(seed);
        return (r % 32'd100) < 32'(pct);
    endfunction

    function automatic addr_chan_t rand_addr();
        addr_chan_t  a;
        logic [31:0] r;
        r = $random(seed);
        a.addr = r;
        a.addr[MMIO_SEL_BIT] = chance(50);
        r = $random(seed);
        a.prot = r[2:0];
        return a;
    endfunction

    // mem answers {addr, ~addr} and mmio its inverse
    function automatic r_chan_t expected_r(input addr_chan_t ar);
        r_chan_t r;
        r.data = {ar.addr, ~ar.addr};
        if (ar.addr[MMIO_SEL_BIT])
            r.data = ~r.data;
        r.resp = RESP_OKAY;
        return r;
    endfunction

    function automatic logic outputs_busy();
        return if_ar_ready_o || if_r_valid_o || ls_ar_ready_o || ls_r_valid_o
            || ls_aw_ready_o || ls_w_ready_o || ls_b_valid_o
            || mem_ar_valid_o || mem_r_ready_o || mem_aw_valid_o || mem_w_valid_o
            || mem_b_ready_o || mmio_ar_valid_o || mmio_r_ready_o || mmio_aw_valid_o
            || mmio_w_valid_o || mmio_b_ready_o;
    endfunction

    task automatic check_write_log(input addr_chan_t aw, input w_chan_t w);
        if (aw.addr[MMIO_SEL_BIT]) begin
            if (i_mmio.aw_log.size() != mmio_logged + 1 || i_mem.aw_log.size() != mem_logged)
                stop_with("A write to mmio was not logged exactly once at mmio only");
            compare_addr(i_mmio.aw_log[mmio_logged], aw, "mmio write address");
            compare_w(i_mmio.w_log[mmio_logged], w, "mmio write data");
            mmio_logged++;
        end else begin
            if (i_mem.aw_log.size() != mem_logged + 1 || i_mmio.aw_log.size() != mmio_logged)
                stop_with("A write to mem was not logged exactly once at mem only");
            compare_addr(i_mem.aw_log[mem_logged], aw, "mem write address");
            compare_w(i_mem.w_log[mem_logged], w, "mem write data");
            mem_logged++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_i = 1'b1;
        go    = 1'b0;
        okay_b.resp = RESP_OKAY;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        repeat (8) begin
            @(posedge clk);
            if (outputs_busy())
                stop_with("A DUT valid or ready output was high after reset with no request");
        end
        go = 1'b1;
        wait (if_count == N_IF_RD && ls_count == N_LS_RD && wr_count == N_LS_WR);
        repeat (4) @(negedge clk);
        if (i_mem.aw_log.size() == mem_logged && i_mmio.aw_log.size() == mmio_logged
                && !i_mem.rd_busy && !i_mmio.rd_busy) begin
            $display("Test passed");
            $finish;
        end else begin
            stop_with("A slave was left with a read or write that no master completed");
        end
    end

    initial begin
        if_ar_valid_i = 1'b0;
        if_ar_i       = '0;
        wait (go);
        @(negedge clk);
        for (int n = 0; n < N_IF_RD; n++) begin
            while (!chance(75))
                @(negedge clk);
            if_ar_i       = rand_addr();
            if_ar_valid_i = 1'b1;
            do begin
                @(posedge clk);
            end while (!if_ar_ready_o);
            @(negedge clk);
            if_ar_valid_i = 1'b0;
        end
    end

    initial begin
        ls_ar_valid_i = 1'b0;
        ls_ar_i       = '0;
        wait (go);
        @(negedge clk);
        for (int n = 0; n < N_LS_RD; n++) begin
            while (!chance(75))
                @(negedge clk);
            ls_ar_i       = rand_addr();
            ls_ar_valid_i = 1'b1;
            do begin
                @(posedge clk);
            end while (!ls_ar_ready_o);
            @(negedge clk);
            ls_ar_valid_i = 1'b0;
        end
    end

    initial begin
        logic        aw_done;
        logic        w_done;
        logic [31:0] r;
        ls_aw_valid_i = 1'b0;
        ls_aw_i       = '0;
        ls_w_valid_i  = 1'b0;
        ls_w_i        = '0;
        wait (go);
        @(negedge clk);
        for (int n = 0; n < N_LS_WR; n++) begin
            while (!chance(60))
                @(negedge clk);
            r = $random(seed);
            ls_aw_i       = rand_addr();
            ls_w_i.data   = {$random(seed), $random(seed)};
            ls_w_i.strb   = r[AXI_STRB_W-1:0];
            ls_aw_valid_i = 1'b1;
            ls_w_valid_i  = 1'b1;
            aw_done = 1'b0;
            w_done  = 1'b0;
            while (!(aw_done && w_done)) begin
                @(posedge clk);
                if (ls_aw_valid_i && ls_aw_ready_o)
                    aw_done = 1'b1;
                if (ls_w_valid_i && ls_w_ready_o)
                    w_done = 1'b1;
                @(negedge clk);
                if (aw_done)
                    ls_aw_valid_i = 1'b0;
                if (w_done)
                    ls_w_valid_i = 1'b0;
            end
        end
    end

    initial begin
        if_r_ready_i = 1'b0;
        ls_r_ready_i = 1'b0;
        ls_b_ready_i = 1'b0;
        forever begin
            @(negedge clk);
            if_r_ready_i = chance(70);
            ls_r_ready_i = chance(70);
            ls_b_ready_i = chance(70);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES)
            stop_with("Timeout: the transactions did not finish within the cycle limit");
        if (!rst_i) begin
            if (if_ar_valid_i && !if_ar_ready_o)
                if_passed += (ls_r_valid_o && ls_r_ready_i) ? 1 : 0;
            else
                if_passed = 0;
            if (ls_ar_valid_i && !ls_ar_ready_o)
                ls_passed += (if_r_valid_o && if_r_ready_i) ? 1 : 0;
            else
                ls_passed = 0;
            if (if_passed > 1 || ls_passed > 1)
                stop_with("Arbitration let one master finish two reads while the other waited");
            if (mem_ar_valid_o && mem_ar_ready_i)
                compare_addr(mem_ar_o, ar_granted, "mem read address");
            if (mmio_ar_valid_o && mmio_ar_ready_i)
                compare_addr(mmio_ar_o, ar_granted, "mmio read address");
            if (if_ar_valid_i && if_ar_ready_o) begin
                if_exp.push_back(if_ar_i);
                ar_granted = if_ar_i;
            end
            if (ls_ar_valid_i && ls_ar_ready_o) begin
                ls_exp.push_back(ls_ar_i);
                ar_granted = ls_ar_i;
            end
            if (ls_aw_valid_i && ls_aw_ready_o)
                aw_exp.push_back(ls_aw_i);
            if (ls_w_valid_i && ls_w_ready_o)
                w_exp.push_back(ls_w_i);
            if (if_r_valid_o && ls_r_valid_o)
                stop_with("A read response was offered to both masters at once");
            if (if_r_valid_o && if_r_ready_i) begin
                if (if_exp.size() == 0)
                    stop_with("The if master got a read response with no read outstanding");
                compare_r(if_r_o, expected_r(if_exp.pop_front()), "if read response");
                if_count++;
            end
            if (ls_r_valid_o && ls_r_ready_i) begin
                if (ls_exp.size() == 0)
                    stop_with("The ls master got a read response with no read outstanding");
                compare_r(ls_r_o, expected_r(ls_exp.pop_front()), "ls read response");
                ls_count++;
            end
            if (ls_b_valid_o && ls_b_ready_i) begin
                if (aw_exp.size() == 0 || w_exp.size() == 0)
                    stop_with("The ls master got a write response with no write outstanding");
                compare_b(ls_b_o, okay_b, "write response");
                check_write_log(aw_exp.pop_front(), w_exp.pop_front());
                wr_count++;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_slave_model #(
    parameter int SEED   = 1,
    parameter bit INVERT = 1'b0
) (
    input  wire                             clk,
    input  wire                             rst_i,
    input  wire                             ar_valid_i,
    output logic                            ar_ready_o,
    input  wire axi_xbar_pkg::addr_chan_t   ar_i,
    output logic                            r_valid_o,
    input  wire                             r_ready_i,
    output axi_xbar_pkg::r_chan_t           r_o,
    input  wire                             aw_valid_i,
    output logic                            aw_ready_o,
    input  wire axi_xbar_pkg::addr_chan_t   aw_i,
    input  wire                             w_valid_i,
    output logic                            w_ready_o,
    input  wire axi_xbar_pkg::w_chan_t      w_i,
    output logic                            b_valid_o,
    input  wire                             b_ready_i,
    output axi_xbar_pkg::b_chan_t           b_o
);
    import axi_xbar_pkg::*;

    integer      seed = SEED;
    addr_chan_t  aw_log[$];  // one entry per write received
    w_chan_t     w_log[$];
    addr_chan_t  rd_q;
    addr_chan_t  aw_q;
    logic        rd_busy;
    logic        aw_have;
    logic        w_have;
    logic        ar_seen;    // valid seen at the last edge
    logic        aw_seen;
    logic        w_seen;
    logic [31:0] rnd;

    always @(posedge clk) begin
        if (rst_i) begin
            rd_busy <= 1'b0;
            aw_have <= 1'b0;
            w_have  <= 1'b0;
            ar_seen <= 1'b0;
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
            rd_q    <= '0;
            aw_q    <= '0;
        end else begin
            ar_seen <= ar_valid_i;
            aw_seen <= aw_valid_i;
            w_seen  <= w_valid_i;
            if (ar_valid_i && ar_ready_o) begin
                rd_busy <= 1'b1;
                rd_q    <= ar_i;
            end else if (r_valid_o && r_ready_i) begin
                rd_busy <= 1'b0;
            end
            if (aw_valid_i && aw_ready_o) begin
                aw_have <= 1'b1;
                aw_q    <= aw_i;
            end
            if (w_valid_i && w_ready_o) begin
                w_have <= 1'b1;
                aw_log.push_back(aw_q); // address came in an earlier cycle
                w_log.push_back(w_i);
            end
            if (b_valid_o && b_ready_i) begin
                aw_have <= 1'b0;
                w_have  <= 1'b0;
            end
        end
    end

    initial begin
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_o        = '0;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        b_valid_o  = 1'b0;
        b_o        = '0;
        forever begin
            @(negedge clk);
            rnd = $random(seed);
            if (rst_i) begin
                ar_ready_o <= 1'b0;
                r_valid_o  <= 1'b0;
                aw_ready_o <= 1'b0;
                w_ready_o  <= 1'b0;
                b_valid_o  <= 1'b0;
            end else begin
                ar_ready_o <= ar_seen && !rd_busy && rnd[0];
                r_valid_o  <= rd_busy && (r_valid_o || rnd[1]); // held until taken
                aw_ready_o <= aw_seen && !aw_have && rnd[2];
                w_ready_o  <= w_seen && aw_have && !w_have && rnd[3];
                b_valid_o  <= aw_have && w_have && (b_valid_o || rnd[4]);
            end
            r_o.data <= {rd_q.addr, ~rd_q.addr} ^ {AXI_DATA_W{INVERT}};
            r_o.resp <= RESP_OKAY;
            b_o.resp <= RESP_OKAY;
        end
    end

endmodule

`default_nettype wire
